// ==== carbon_platform_top.f ====
design/carbon_memmap_pkg.sv
design/carbon_arch_pkg.sv
design/bringup_sequencer.sv
design/csr_bank.sv
design/bus_decoder.sv
design/discovery_rom.sv
design/mmio_regs.sv
design/platform_sram.sv
design/carbon_platform_top.sv
tb/carbon_platform_props.sv
tb/carbon_platform_tb.sv

// ==== design/bringup_sequencer.sv ====
// --------------------------------------------------------------------------
// Bring-up CSR sequencer and CPU release
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module bringup_sequencer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      csr_wr_ack,
  output logic                      csr_wr_valid,
  output carbon_arch_pkg::csr_idx_t csr_wr_idx,
  output carbon_memmap_pkg::data_t  csr_wr_data,
  output logic                      cpu_halt,
  output logic                      run_pulse
);
  import carbon_memmap_pkg::*;
  import carbon_arch_pkg::*;

  typedef enum logic [1:0] {
    SEQ_ISSUE,
    SEQ_WAIT,
    SEQ_DONE
  } seq_state_e;

  seq_state_e state_q;
  logic [$clog2(BRINGUP_STEPS)-1:0] step_q;

  // One write per ISSUE cycle, straight from the table
  assign csr_wr_valid = (state_q == SEQ_ISSUE);
  assign csr_wr_idx   = BRINGUP_IDX[step_q];
  assign csr_wr_data  = data_t'(BRINGUP_DATA[step_q]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= SEQ_ISSUE;
      step_q    <= '0;
      cpu_halt  <= 1'b1;
      run_pulse <= 1'b0;
    end else begin
      run_pulse <= 1'b0;
      case (state_q)
        SEQ_ISSUE: state_q <= SEQ_WAIT;
        SEQ_WAIT: begin
          if (csr_wr_ack) begin
            if (step_q == BRINGUP_STEPS - 1) begin
              // Last write landed, let the CPU run
              state_q   <= SEQ_DONE;
              cpu_halt  <= 1'b0;
              run_pulse <= 1'b1;
            end else begin
              step_q  <= step_q + 1'b1;
              state_q <= SEQ_ISSUE;
            end
          end
        end
        default: state_q <= SEQ_DONE;
      endcase
    end
  end

endmodule : bringup_sequencer

// ==== design/bus_decoder.sv ====
// --------------------------------------------------------------------------
// Request decode and response pipeline
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module bus_decoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cpu_halt,
  input  logic                          req_valid,
  input  logic                          req_write,
  input  carbon_memmap_pkg::addr_t      req_addr,
  input  carbon_memmap_pkg::data_t      req_wdata,
  output logic                          resp_valid,
  output carbon_memmap_pkg::data_t      resp_rdata,
  output logic                          resp_err,
  output logic                          sel_disc,
  output logic                          sel_csr,
  output logic                          sel_mmio,
  output logic                          sel_ram,
  output logic                          tgt_write,
  output carbon_memmap_pkg::word_idx_t  tgt_idx,
  output carbon_memmap_pkg::data_t      tgt_wdata,
  input  carbon_arch_pkg::disc_word_t   disc_rdata,
  input  carbon_memmap_pkg::data_t      csr_rdata,
  input  carbon_memmap_pkg::data_t      mmio_rdata,
  input  carbon_memmap_pkg::data_t      ram_rdata
);
  import carbon_memmap_pkg::*;

  target_e   req_target;
  logic      req_err;

  logic      s1_valid;
  logic      s1_write;
  logic      s1_err;
  target_e   s1_target;
  word_idx_t s1_idx;
  data_t     s1_wdata;

  logic      s2_valid;
  logic      s2_err;
  logic      s2_read;
  target_e   s2_target;

  // Window match, RAM is the default
  always_comb begin
    if ((req_addr & DISCOVERY_MASK) == DISCOVERY_BASE) begin
      req_target = TGT_DISCOVERY;
    end else if ((req_addr & CSR_MASK) == CSR_BASE) begin
      req_target = TGT_CSR;
    end else if ((req_addr & MMIO_MASK) == MMIO_BASE) begin
      req_target = TGT_MMIO;
    end else begin
      req_target = TGT_RAM;
    end
  end

  // Halted CPU, or a write to a read-only window
  assign req_err = cpu_halt ||
                   (req_write && (req_target == TGT_DISCOVERY || req_target == TGT_CSR));

  // --------------------------------------------------------------------------
  // Stage 1 and target strobes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s1_write  <= 1'b0;
      s1_err    <= 1'b0;
      s1_target <= TGT_RAM;
    end else begin
      s1_valid  <= req_valid;
      s1_write  <= req_write;
      s1_err    <= req_valid && req_err;
      s1_target <= req_target;
    end
  end

  always_ff @(posedge clk) begin
    s1_idx   <= req_addr[9:2];
    s1_wdata <= req_wdata;
  end

  assign sel_disc  = s1_valid && !s1_err && (s1_target == TGT_DISCOVERY);
  assign sel_csr   = s1_valid && !s1_err && (s1_target == TGT_CSR);
  assign sel_mmio  = s1_valid && !s1_err && (s1_target == TGT_MMIO);
  assign sel_ram   = s1_valid && !s1_err && (s1_target == TGT_RAM);
  assign tgt_write = s1_write;
  assign tgt_idx   = s1_idx;
  assign tgt_wdata = s1_wdata;

  // --------------------------------------------------------------------------
  // Stage 2 and response mux
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid  <= 1'b0;
      s2_err    <= 1'b0;
      s2_read   <= 1'b0;
      s2_target <= TGT_RAM;
    end else begin
      s2_valid  <= s1_valid;
      s2_err    <= s1_err;
      s2_read   <= s1_valid && !s1_write && !s1_err;
      s2_target <= s1_target;
    end
  end

  assign resp_valid = s2_valid;
  assign resp_err   = s2_err;

  // Data only for good reads
  always_comb begin
    resp_rdata = '0;
    if (s2_read) begin
      case (s2_target)
        TGT_DISCOVERY: resp_rdata = disc_rdata;
        TGT_CSR:       resp_rdata = csr_rdata;
        TGT_MMIO:      resp_rdata = mmio_rdata;
        default:       resp_rdata = ram_rdata;
      endcase
    end
  end

endmodule : bus_decoder

// ==== design/carbon_arch_pkg.sv ====
// --------------------------------------------------------------------------
// Architecture constants and discovery table
// --------------------------------------------------------------------------
package carbon_arch_pkg;

  typedef logic [2:0]  csr_idx_t;
  typedef logic [31:0] disc_word_t;

  localparam csr_idx_t CSR_MODEFLAGS      = 3'd0;
  localparam csr_idx_t CSR_AM9513_CTRL    = 3'd1;
  localparam csr_idx_t CSR_AM9513_MODE    = 3'd2;
  localparam csr_idx_t CSR_COMP_BASE_LO   = 3'd3;
  localparam csr_idx_t CSR_COMP_BASE_HI   = 3'd4;
  localparam csr_idx_t CSR_COMP_RING_MASK = 3'd5;
  localparam csr_idx_t CSR_CAI_IRQ_ENABLE = 3'd6;
  localparam int       CSR_COUNT          = 7;

  localparam logic [7:0] MODE_NATIVE_MASK = 8'h04;
  localparam logic [7:0] AM9513_P2_AM9513 = 8'd2;

  // Tier and ladder ids presented through discovery
  localparam logic [7:0] CPU_TIER_P6_Z380   = 8'd6;
  localparam logic [7:0] FPU_TIER_P2_AM9513 = 8'd2;
  localparam logic [7:0] LADDER_Z80         = 8'd1;
  localparam logic [7:0] LADDER_AM95        = 8'd2;

  // --------------------------------------------------------------------------
  // Bring-up writes, in issue order
  // --------------------------------------------------------------------------
  localparam int BRINGUP_STEPS = 7;

  localparam csr_idx_t BRINGUP_IDX [BRINGUP_STEPS] = '{
    CSR_MODEFLAGS, CSR_AM9513_CTRL, CSR_AM9513_MODE, CSR_COMP_BASE_LO,
    CSR_COMP_BASE_HI, CSR_COMP_RING_MASK, CSR_CAI_IRQ_ENABLE
  };

  localparam logic [31:0] BRINGUP_DATA [BRINGUP_STEPS] = '{
    32'(MODE_NATIVE_MASK), 32'h0000_0001, 32'(AM9513_P2_AM9513), 32'h0000_0500,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000
  };

  // --------------------------------------------------------------------------
  // Discovery table
  // --------------------------------------------------------------------------
  localparam logic [7:0] DISC_OFF_SIGNATURE   = 8'h00;
  localparam logic [7:0] DISC_OFF_HEADER      = 8'h04;
  localparam logic [7:0] DISC_OFF_TIERS       = 8'h08;
  localparam logic [7:0] DISC_OFF_CPU_FEAT    = 8'h60;
  localparam logic [7:0] DISC_OFF_FPU_FEAT    = 8'h70;
  localparam logic [7:0] DISC_OFF_PERIPH_FEAT = 8'h80;

  localparam disc_word_t DISC_SIGNATURE   = 32'h4353_4443;
  localparam disc_word_t DISC_HEADER      = {16'd64, 16'd1};
  localparam disc_word_t DISC_TIERS       =
      {LADDER_AM95, LADDER_Z80, FPU_TIER_P2_AM9513, CPU_TIER_P6_Z380};
  localparam disc_word_t DISC_CPU_FEAT    = 32'h0000_001F;
  localparam disc_word_t DISC_FPU_FEAT    = 32'h0000_0001;
  localparam disc_word_t DISC_PERIPH_FEAT = 32'h0000_000F;

  // Word at a byte offset, 0 where nothing is defined
  function automatic disc_word_t disc_lookup(input logic [7:0] byte_off);
    disc_word_t word;
    case (byte_off)
      DISC_OFF_SIGNATURE:   word = DISC_SIGNATURE;
      DISC_OFF_HEADER:      word = DISC_HEADER;
      DISC_OFF_TIERS:       word = DISC_TIERS;
      DISC_OFF_CPU_FEAT:    word = DISC_CPU_FEAT;
      DISC_OFF_FPU_FEAT:    word = DISC_FPU_FEAT;
      DISC_OFF_PERIPH_FEAT: word = DISC_PERIPH_FEAT;
      default:              word = '0;
    endcase
    return word;
  endfunction

endpackage : carbon_arch_pkg

// ==== design/carbon_memmap_pkg.sv ====
// --------------------------------------------------------------------------
// Platform address map and bus types
// --------------------------------------------------------------------------
package carbon_memmap_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Word index carried to the targets (byte address bits 9:2)
  typedef logic [7:0] word_idx_t;

  typedef enum logic [1:0] {
    TGT_DISCOVERY,
    TGT_CSR,
    TGT_MMIO,
    TGT_RAM
  } target_e;

  // --------------------------------------------------------------------------
  // Windows, hit when (addr & MASK) == BASE
  // --------------------------------------------------------------------------
  localparam addr_t DISCOVERY_BASE = 32'h0001_0000;
  localparam addr_t DISCOVERY_MASK = 32'hFFFF_FF00;

  localparam addr_t CSR_BASE = 32'h0002_0000;
  localparam addr_t CSR_MASK = 32'hFFFF_FFE0;

  localparam addr_t MMIO_BASE = 32'h0003_0000;
  localparam addr_t MMIO_MASK = 32'hFFFF_FFF0;

  // MMIO word layout
  localparam logic [1:0] MMIO_WORD_SIGNATURE = 2'd0;
  localparam logic [1:0] MMIO_WORD_POWEROFF  = 2'd1;

endpackage : carbon_memmap_pkg

// ==== design/carbon_platform_top.sv ====
// --------------------------------------------------------------------------
// Carbon platform top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module carbon_platform_top #(
  parameter int CREDITS   = 2,
  parameter int RAM_WORDS = 256
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid,
  input  logic                     req_write,
  input  carbon_memmap_pkg::addr_t req_addr,
  input  carbon_memmap_pkg::data_t req_wdata,
  output logic                     resp_valid,
  output carbon_memmap_pkg::data_t resp_rdata,
  output logic                     resp_err,
  output logic                     cpu_halt,
  output logic                     run_pulse,
  output carbon_memmap_pkg::data_t signature,
  output logic                     poweroff
);
  import carbon_memmap_pkg::*;
  import carbon_arch_pkg::*;

  logic       csr_wr_valid;
  csr_idx_t   csr_wr_idx;
  data_t      csr_wr_data;
  logic       csr_wr_ack;

  logic       sel_disc;
  logic       sel_csr;
  logic       sel_mmio;
  logic       sel_ram;
  logic       tgt_write;
  word_idx_t  tgt_idx;
  data_t      tgt_wdata;

  disc_word_t disc_rdata;
  data_t      csr_rdata;
  data_t      mmio_rdata;
  data_t      ram_rdata;

  bringup_sequencer u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_ack   (csr_wr_ack),
    .csr_wr_valid (csr_wr_valid),
    .csr_wr_idx   (csr_wr_idx),
    .csr_wr_data  (csr_wr_data),
    .cpu_halt     (cpu_halt),
    .run_pulse    (run_pulse)
  );

  csr_bank u_csr (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_valid (csr_wr_valid),
    .csr_wr_idx   (csr_wr_idx),
    .csr_wr_data  (csr_wr_data),
    .csr_wr_ack   (csr_wr_ack),
    .rd_sel       (sel_csr),
    .rd_idx       (tgt_idx[2:0]),
    .rd_data      (csr_rdata)
  );

  bus_decoder u_dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_halt   (cpu_halt),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .sel_disc   (sel_disc),
    .sel_csr    (sel_csr),
    .sel_mmio   (sel_mmio),
    .sel_ram    (sel_ram),
    .tgt_write  (tgt_write),
    .tgt_idx    (tgt_idx),
    .tgt_wdata  (tgt_wdata),
    .disc_rdata (disc_rdata),
    .csr_rdata  (csr_rdata),
    .mmio_rdata (mmio_rdata),
    .ram_rdata  (ram_rdata)
  );

  discovery_rom u_disc (
    .clk   (clk),
    .rst_n (rst_n),
    .sel   (sel_disc),
    .idx   (tgt_idx),
    .rdata (disc_rdata)
  );

  mmio_regs u_mmio (
    .clk       (clk),
    .rst_n     (rst_n),
    .sel       (sel_mmio),
    .write     (tgt_write),
    .idx       (tgt_idx),
    .wdata     (tgt_wdata),
    .rdata     (mmio_rdata),
    .signature (signature),
    .poweroff  (poweroff)
  );

  platform_sram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_ram (
    .clk   (clk),
    .sel   (sel_ram),
    .write (tgt_write),
    .idx   (tgt_idx),
    .wdata (tgt_wdata),
    .rdata (ram_rdata)
  );

endmodule : carbon_platform_top

// ==== design/csr_bank.sv ====
// --------------------------------------------------------------------------
// Configuration register bank
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module csr_bank (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      csr_wr_valid,
  input  carbon_arch_pkg::csr_idx_t csr_wr_idx,
  input  carbon_memmap_pkg::data_t  csr_wr_data,
  output logic                      csr_wr_ack,
  input  logic                      rd_sel,
  input  carbon_arch_pkg::csr_idx_t rd_idx,
  output carbon_memmap_pkg::data_t  rd_data
);
  import carbon_memmap_pkg::*;
  import carbon_arch_pkg::*;

  data_t regs_q [CSR_COUNT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < CSR_COUNT; i++) begin
        regs_q[i] <= '0;
      end
      csr_wr_ack <= 1'b0;
    end else begin
      csr_wr_ack <= csr_wr_valid;
      if (csr_wr_valid && (csr_wr_idx < CSR_COUNT)) begin
        regs_q[csr_wr_idx] <= csr_wr_data;
      end
    end
  end

  // Index 7 is unimplemented
  always_ff @(posedge clk) begin
    if (rd_sel) begin
      rd_data <= (rd_idx < CSR_COUNT) ? regs_q[rd_idx] : '0;
    end
  end

endmodule : csr_bank

// ==== design/discovery_rom.sv ====
// --------------------------------------------------------------------------
// Discovery table ROM
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module discovery_rom (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         sel,
  input  carbon_memmap_pkg::word_idx_t idx,
  output carbon_arch_pkg::disc_word_t  rdata
);
  import carbon_arch_pkg::*;

  logic [7:0] byte_off;

  // 256-byte window, 64 words
  assign byte_off = {idx[5:0], 2'b00};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (sel) begin
      rdata <= disc_lookup(byte_off);
    end
  end

endmodule : discovery_rom

// ==== design/mmio_regs.sv ====
// --------------------------------------------------------------------------
// Signature and poweroff registers
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module mmio_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         sel,
  input  logic                         write,
  input  carbon_memmap_pkg::word_idx_t idx,
  input  carbon_memmap_pkg::data_t     wdata,
  output carbon_memmap_pkg::data_t     rdata,
  output carbon_memmap_pkg::data_t     signature,
  output logic                         poweroff
);
  import carbon_memmap_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      signature <= '0;
      poweroff  <= 1'b0;
    end else if (sel && write) begin
      if (idx[1:0] == MMIO_WORD_SIGNATURE) begin
        signature <= wdata;
      end
      // Sticky until reset
      if (idx[1:0] == MMIO_WORD_POWEROFF && wdata[0]) begin
        poweroff <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel && !write) begin
      case (idx[1:0])
        MMIO_WORD_SIGNATURE: rdata <= signature;
        MMIO_WORD_POWEROFF:  rdata <= {31'b0, poweroff};
        default:             rdata <= '0;
      endcase
    end
  end

endmodule : mmio_regs

// ==== design/platform_sram.sv ====
// --------------------------------------------------------------------------
// Default target word RAM
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module platform_sram #(
  parameter int RAM_WORDS = 256
) (
  input  logic                         clk,
  input  logic                         sel,
  input  logic                         write,
  input  carbon_memmap_pkg::word_idx_t idx,
  input  carbon_memmap_pkg::data_t     wdata,
  output carbon_memmap_pkg::data_t     rdata
);
  import carbon_memmap_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  data_t mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (sel && write) begin
      mem[idx[AW-1:0]] <= wdata;
    end
    if (sel && !write) begin
      rdata <= mem[idx[AW-1:0]];
    end
  end

endmodule : platform_sram

// ==== tb/carbon_platform_props.sv ====
// --------------------------------------------------------------------------
// Bus and release assertions
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module carbon_platform_props #(
  parameter int CREDITS = 2
) (
  input logic clk,
  input logic rst_n,
  input logic req_valid,
  input logic resp_valid,
  input logic cpu_halt,
  input logic run_pulse
);

  int inflight_q;
  int fail_count = 0;

  task automatic note_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight_q <= 0;
    end else begin
      inflight_q <= inflight_q + int'(req_valid) - int'(resp_valid);
    end
  end

  // Fixed two-cycle latency in both directions
  assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> ##2 resp_valid)
    else note_failure("no response two cycles after a request");
  assert property (@(posedge clk) disable iff (!rst_n) resp_valid |-> $past(req_valid, 2))
    else note_failure("response without a request two cycles before");

  assert property (@(posedge clk) disable iff (!rst_n) inflight_q <= CREDITS)
    else note_failure("more requests in flight than credits");

  // Release is a single pulse at the halt edge
  assert property (@(posedge clk) disable iff (!rst_n)
                   run_pulse |-> $fell(cpu_halt) ##1 !run_pulse)
    else note_failure("run_pulse not a single cycle at the halt release");
  assert property (@(posedge clk) disable iff (!rst_n) $fell(cpu_halt) |-> run_pulse)
    else note_failure("cpu_halt fell without run_pulse");
  assert property (@(posedge clk) disable iff (!rst_n) !cpu_halt |=> !cpu_halt)
    else note_failure("cpu_halt rose again after release");

endmodule : carbon_platform_props

bind carbon_platform_top carbon_platform_props #(
  .CREDITS (CREDITS)
) u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req_valid  (req_valid),
  .resp_valid (resp_valid),
  .cpu_halt   (cpu_halt),
  .run_pulse  (run_pulse)
);

// ==== tb/carbon_platform_tb.sv ====
// --------------------------------------------------------------------------
// Carbon platform testbench
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module carbon_platform_tb;
  import carbon_memmap_pkg::*;

  localparam int CREDITS      = 2;
  localparam int RAM_WORDS    = 256;
  localparam int NUM_TESTS    = 5;
  localparam int TXN_PER_TEST = 40;
  localparam int WATCHDOG_NS  = (NUM_TESTS * TXN_PER_TEST + 100) * 10;

  logic  clk;
  logic  rst_n;
  logic  req_valid;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  logic  resp_valid;
  data_t resp_rdata;
  logic  resp_err;
  logic  cpu_halt;
  logic  run_pulse;
  data_t signature;
  logic  poweroff;

  // Expected responses with the oldest first
  logic  exp_err_q [$];
  data_t exp_data_q [$];
  int    exp_cyc_q [$];

  data_t ram_model [int];
  int    ram_keys [$];
  data_t sig_model;
  logic  poweroff_model;
  data_t csr_expect [8] = '{32'h4, 32'h1, 32'h2, 32'h500, 32'h0, 32'h0, 32'h0, 32'h0};
  logic [7:0] disc_offs [6] = '{8'h00, 8'h04, 8'h08, 8'h60, 8'h70, 8'h80};

  int credits;
  int cycle;
  int checks;
  int errors;
  int errors_before;
  int tests;

  carbon_platform_top #(
    .CREDITS   (CREDITS),
    .RAM_WORDS (RAM_WORDS)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_err   (resp_err),
    .cpu_halt   (cpu_halt),
    .run_pulse  (run_pulse),
    .signature  (signature),
    .poweroff   (poweroff)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Advance one clock and compare any response with the queue head
  task automatic tick();
    @(posedge clk);
    #1;
    cycle++;
    if (resp_valid) begin
      credits++;
      if (exp_err_q.size() == 0) begin
        errors++;
        $display("response at %0t ns with no request outstanding", $time);
      end else begin
        check_value("resp_err", 32'(resp_err), 32'(exp_err_q.pop_front()));
        check_value("resp_rdata", resp_rdata, exp_data_q.pop_front());
        check_value("resp_cycle", cycle, exp_cyc_q.pop_front());
      end
    end
  endtask

  task automatic issue(input logic write, input addr_t addr, input data_t wdata,
                       input logic exp_err, input data_t exp_data);
    while (credits == 0) begin
      tick();
    end
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    credits--;
    exp_err_q.push_back(exp_err);
    exp_data_q.push_back(exp_data);
    exp_cyc_q.push_back(cycle + 2);
    tick();
    req_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    while (exp_err_q.size() != 0) begin
      tick();
    end
    tests++;
    $display("test %s done, %0d errors", name, errors - errors_before);
    errors_before = errors;
  endtask

  function automatic data_t disc_expect(input logic [7:0] off);
    case (off)
      8'h00:   return 32'h4353_4443;
      8'h04:   return 32'h0040_0001;
      8'h08:   return 32'h0201_0206;
      8'h60:   return 32'h0000_001F;
      8'h70:   return 32'h0000_0001;
      8'h80:   return 32'h0000_000F;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic hits_window(input addr_t addr);
    return ((addr & DISCOVERY_MASK) == DISCOVERY_BASE) ||
           ((addr & CSR_MASK) == CSR_BASE) || ((addr & MMIO_MASK) == MMIO_BASE);
  endfunction

  // Random RAM address for a word that misses every window
  function automatic addr_t ram_addr(input int word);
    addr_t addr;
    do begin
      addr      = $urandom();
      addr[9:2] = 8'(word);
      addr[1:0] = 2'b00;
    end while (hits_window(addr));
    return addr;
  endfunction

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int         word;
    data_t      val;
    logic [7:0] off;
    void'($urandom(8591));
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_wdata      = '0;
    sig_model      = '0;
    poweroff_model = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n   = 1'b1;
    credits = CREDITS;

    // ------------------------------------------------------------------------
    // Release
    // ------------------------------------------------------------------------
    check_value("cpu_halt", 32'(cpu_halt), 32'd1);
    check_value("run_pulse", 32'(run_pulse), 32'd0);
    issue(1'b0, 32'h0000_0040, '0, 1'b1, '0);
    issue(1'b1, MMIO_BASE, 32'hDEAD_BEEF, 1'b1, '0);
    while (!run_pulse) begin
      check_value("cpu_halt", 32'(cpu_halt), 32'd1);
      tick();
    end
    check_value("cpu_halt", 32'(cpu_halt), 32'd0);
    tick();
    check_value("run_pulse", 32'(run_pulse), 32'd0);
    check_value("signature", signature, sig_model);
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, CSR_BASE + 32'(i * 4), '0, 1'b0, csr_expect[i]);
    end
    finish_test("release");

    // ------------------------------------------------------------------------
    // Discovery
    // ------------------------------------------------------------------------
    for (int i = 0; i < 24; i++) begin
      if (i % 2 == 0) begin
        off = disc_offs[$urandom_range(0, 5)];
      end else begin
        off = 8'($urandom_range(0, 63) * 4);
      end
      issue(1'b0, DISCOVERY_BASE | 32'(off), '0, 1'b0, disc_expect(off));
    end
    issue(1'b1, DISCOVERY_BASE | 32'h60, 32'h1234_5678, 1'b1, '0);
    issue(1'b0, DISCOVERY_BASE | 32'h60, '0, 1'b0, disc_expect(8'h60));
    finish_test("discovery");

    // ------------------------------------------------------------------------
    // RAM
    // ------------------------------------------------------------------------
    for (int i = 0; i < TXN_PER_TEST - 2; i++) begin
      if (ram_keys.size() == 0 || $urandom_range(0, 1) == 0) begin
        word = $urandom_range(0, RAM_WORDS - 1);
        val  = $urandom();
        if (!ram_model.exists(word)) begin
          ram_keys.push_back(word);
        end
        ram_model[word] = val;
        issue(1'b1, ram_addr(word), val, 1'b0, '0);
      end else begin
        word = ram_keys[$urandom_range(0, ram_keys.size() - 1)];
        issue(1'b0, ram_addr(word), '0, 1'b0, ram_model[word]);
      end
    end
    // Read right behind a write to the same word
    val = $urandom();
    ram_model[5] = val;
    issue(1'b1, ram_addr(5), val, 1'b0, '0);
    issue(1'b0, ram_addr(5), '0, 1'b0, ram_model[5]);
    finish_test("ram");

    // ------------------------------------------------------------------------
    // MMIO
    // ------------------------------------------------------------------------
    check_value("poweroff", 32'(poweroff), 32'(poweroff_model));
    sig_model = $urandom();
    issue(1'b1, MMIO_BASE, sig_model, 1'b0, '0);
    finish_test_wait: begin
      while (exp_err_q.size() != 0) begin
        tick();
      end
    end
    check_value("signature", signature, sig_model);
    issue(1'b0, MMIO_BASE, '0, 1'b0, sig_model);
    poweroff_model = 1'b1;
    issue(1'b1, MMIO_BASE + 32'h4, 32'h1, 1'b0, '0);
    issue(1'b1, MMIO_BASE + 32'h4, 32'h0, 1'b0, '0);
    issue(1'b0, MMIO_BASE + 32'h4, '0, 1'b0, {31'b0, poweroff_model});
    issue(1'b0, MMIO_BASE + 32'h8, '0, 1'b0, '0);
    finish_test("mmio");
    check_value("poweroff", 32'(poweroff), 32'(poweroff_model));

    // ------------------------------------------------------------------------
    // CSR protection
    // ------------------------------------------------------------------------
    for (int i = 0; i < 8; i++) begin
      issue(1'b1, CSR_BASE + 32'(i * 4), $urandom(), 1'b1, '0);
      issue(1'b0, CSR_BASE + 32'(i * 4), '0, 1'b0, csr_expect[i]);
    end
    finish_test("csr_protect");

    if (uut.u_props.fail_count != 0) begin
      errors += uut.u_props.fail_count;
      $display("bound assertions failed %0d times", uut.u_props.fail_count);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : carbon_platform_tb
